// File: design/pcie_map_pkg.sv
`default_nettype none

package pcie_map_pkg;

    // host byte address seen on pcie port 0
    localparam int PCIE_ADDR_WIDTH = 16;

    // page index starts at the 4 KB boundary
    localparam int PAGE_LSB = 12;

    // 64-byte line number starts here
    localparam int LINE_LSB = 6;

    localparam int REGS_PER_PAGE   = 4;
    localparam int DWORD_WIDTH     = 32;
    localparam int BYTES_PER_DWORD = 4;

    // lines below this one hold the per-queue pages
    localparam int RB_BRAM_OFFSET = 4;

    // dword order inside a queue page
    typedef enum logic [1:0] {
        TAIL,
        HEAD,
        KMEM_LOW,
        KMEM_HIGH
    } reg_slot_t;

endpackage

`default_nettype wire

// File: design/queue_pkg.sv
`default_nettype none

package queue_pkg;

    // queue index width, bounds the number of pages
    localparam int APP_IDX_WIDTH = 2;

    localparam int MAX_QUEUES = 4;

    // width of the host queue-count input
    localparam int QCOUNT_WIDTH = 5;

    // ring pointers, one dword each
    localparam int PTR_WIDTH = 32;

    localparam int KMEM_ADDR_WIDTH = 2 * PTR_WIDTH;

    typedef logic [APP_IDX_WIDTH-1:0] queue_idx_t;

    typedef logic [PTR_WIDTH-1:0] ptr_t;

    // kernel buffer address, low dword in the lower half
    typedef logic [KMEM_ADDR_WIDTH-1:0] kmem_addr_t;

endpackage

`default_nettype wire

// File: design/pio_write_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module pio_write_decoder (
    input  logic [pcie_map_pkg::PCIE_ADDR_WIDTH-1:0]        pcie_address_0,
    input  logic                                            pcie_write_0,
    input  logic [511:0]                                    pcie_writedata_0,
    input  logic [63:0]                                     pcie_byteenable_0,
    output logic [pcie_map_pkg::REGS_PER_PAGE-1:0]          slot_wr_en,
    output queue_pkg::queue_idx_t                           wr_page,
    output queue_pkg::ptr_t [pcie_map_pkg::REGS_PER_PAGE-1:0] wr_dword
);

    import pcie_map_pkg::*;
    import queue_pkg::*;

    // a slot counts only when its whole dword is enabled
    always_comb begin
        for (int s = 0; s < REGS_PER_PAGE; s++) begin
            slot_wr_en[s] = pcie_write_0 &&
                (&pcie_byteenable_0[s*BYTES_PER_DWORD +: BYTES_PER_DWORD]);
        end
    end

    // low dwords of the line, one per page slot
    always_comb begin
        for (int s = 0; s < REGS_PER_PAGE; s++) begin
            wr_dword[s] = pcie_writedata_0[s*DWORD_WIDTH +: DWORD_WIDTH];
        end
    end

    // page index sits right above the 4 KB offset
    assign wr_page = pcie_address_0[PAGE_LSB +: APP_IDX_WIDTH];

endmodule

`default_nettype wire

// File: design/queue_table.sv
`timescale 1ns/1ps
`default_nettype none

module queue_table #(
    parameter int NB_QUEUES = queue_pkg::MAX_QUEUES
) (
    input  logic                                             pcie_clk,
    // port a: switcher side
    input  queue_pkg::queue_idx_t                            addr_a,
    input  logic                                             rd_en_a,
    input  logic                                             wr_en_a,
    input  queue_pkg::ptr_t                                  tail_wr_data_a,
    // port b: host writes
    input  logic [pcie_map_pkg::REGS_PER_PAGE-1:0]           slot_wr_en_b,
    input  queue_pkg::queue_idx_t                            addr_b,
    input  queue_pkg::ptr_t [pcie_map_pkg::REGS_PER_PAGE-1:0] wr_dword_b,
    output queue_pkg::ptr_t                                  tail_a,
    output queue_pkg::ptr_t                                  head_a,
    output queue_pkg::kmem_addr_t                            kmem_addr_a
);

    import pcie_map_pkg::*;
    import queue_pkg::*;

    ptr_t [REGS_PER_PAGE-1:0] rd_data;

    // one memory per page slot
    for (genvar f = 0; f < REGS_PER_PAGE; f++) begin : g_field
        ptr_t mem [NB_QUEUES];
        ptr_t rd_q1;
        ptr_t rd_q2;

        always_ff @(posedge pcie_clk) begin
            if (slot_wr_en_b[f]) begin
                mem[addr_b] <= wr_dword_b[f];
            end
            // port a only saves tails, and wins a same-address clash
            if (f == int'(TAIL) && wr_en_a) begin
                mem[addr_a] <= tail_wr_data_a;
            end
        end

        // two-stage read, like a bram with output register
        always_ff @(posedge pcie_clk) begin
            if (rd_en_a) begin
                rd_q1 <= mem[addr_a];
            end
            rd_q2 <= rd_q1;
        end

        assign rd_data[f] = rd_q2;
    end

    assign tail_a      = rd_data[TAIL];
    assign head_a      = rd_data[HEAD];
    assign kmem_addr_a = {rd_data[KMEM_HIGH], rd_data[KMEM_LOW]};

endmodule

`default_nettype wire

// File: design/queue_switcher.sv
`timescale 1ns/1ps
`default_nettype none

module queue_switcher #(
    parameter int NB_QUEUES = queue_pkg::MAX_QUEUES
) (
    input  logic                                             pcie_clk,
    input  logic                                             pcie_reset_n,
    input  logic [queue_pkg::QCOUNT_WIDTH-1:0]               nb_queues,
    input  logic                                             dma_done,
    input  queue_pkg::ptr_t                                  new_tail,
    input  logic [pcie_map_pkg::REGS_PER_PAGE-1:0]           slot_wr_en,
    input  queue_pkg::queue_idx_t                            wr_page,
    input  queue_pkg::ptr_t [pcie_map_pkg::REGS_PER_PAGE-1:0] wr_dword,
    input  queue_pkg::ptr_t                                  tail_a,
    input  queue_pkg::ptr_t                                  head_a,
    input  queue_pkg::kmem_addr_t                            kmem_addr_a,
    output queue_pkg::queue_idx_t                            addr_a,
    output logic                                             rd_en_a,
    output logic                                             wr_en_a,
    output queue_pkg::ptr_t                                  tail_wr_data_a,
    output queue_pkg::queue_idx_t                            active_queue,
    output queue_pkg::ptr_t                                  f2c_head,
    output queue_pkg::ptr_t                                  f2c_tail,
    output queue_pkg::kmem_addr_t                            f2c_kmem_addr
);

    import pcie_map_pkg::*;
    import queue_pkg::*;

    typedef enum logic [1:0] {
        IDLE,
        TABLE_WAIT_1,
        TABLE_WAIT_2,
        SWITCH_QUEUE
    } state_t;

    state_t                  state;
    queue_idx_t              next_queue;
    queue_idx_t              rd_addr;
    logic [QCOUNT_WIDTH-1:0] last_queue;

    // highest queue in the round, limited to what the table holds
    always_comb begin
        if (nb_queues > QCOUNT_WIDTH'(NB_QUEUES)) begin
            last_queue = QCOUNT_WIDTH'(NB_QUEUES - 1);
        end else if (nb_queues == '0) begin
            last_queue = '0;
        end else begin
            last_queue = nb_queues - QCOUNT_WIDTH'(1);
        end
    end

    // save the outgoing tail in the same cycle the new state is loaded
    assign wr_en_a        = (state == SWITCH_QUEUE);
    assign tail_wr_data_a = f2c_tail;
    assign addr_a         = wr_en_a ? active_queue : rd_addr;

    always_ff @(posedge pcie_clk) begin
        rd_en_a <= 1'b0;
        if (!pcie_reset_n) begin
            state         <= IDLE;
            active_queue  <= '0;
            next_queue    <= (last_queue != '0) ? queue_idx_t'(1) : '0;
            f2c_head      <= '0;
            f2c_tail      <= '0;
            f2c_kmem_addr <= '0;
        end else begin
            // host updates to the live queue go straight to the f2c copy
            if (wr_page == active_queue) begin
                if (slot_wr_en[TAIL]) begin
                    f2c_tail <= wr_dword[TAIL];
                end
                if (slot_wr_en[HEAD]) begin
                    f2c_head <= wr_dword[HEAD];
                end
                if (slot_wr_en[KMEM_LOW]) begin
                    f2c_kmem_addr[PTR_WIDTH-1:0] <= wr_dword[KMEM_LOW];
                end
                if (slot_wr_en[KMEM_HIGH]) begin
                    f2c_kmem_addr[KMEM_ADDR_WIDTH-1:PTR_WIDTH] <= wr_dword[KMEM_HIGH];
                end
            end

            case (state)
                IDLE: begin
                    if (dma_done) begin
                        // fetch next queue while keeping the dma's tail
                        rd_addr  <= next_queue;
                        rd_en_a  <= 1'b1;
                        f2c_tail <= new_tail;
                        state    <= TABLE_WAIT_1;
                    end
                end
                TABLE_WAIT_1: begin
                    state <= TABLE_WAIT_2;
                end
                TABLE_WAIT_2: begin
                    state <= SWITCH_QUEUE;
                end
                SWITCH_QUEUE: begin
                    f2c_head      <= head_a;
                    f2c_kmem_addr <= kmem_addr_a;
                    // single queue: table tail is stale, keep the live one
                    if (last_queue != '0) begin
                        f2c_tail <= tail_a;
                    end
                    active_queue <= next_queue;
                    if (QCOUNT_WIDTH'(next_queue) >= last_queue) begin
                        next_queue <= '0;
                    end else begin
                        next_queue <= next_queue + queue_idx_t'(1);
                    end
                    state <= IDLE;
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// File: design/pio_reg_file.sv
`timescale 1ns/1ps
`default_nettype none

module pio_reg_file #(
    parameter int NB_QUEUES = queue_pkg::MAX_QUEUES
) (
    input  logic                                             pcie_clk,
    input  logic                                             pcie_reset_n,
    input  logic [pcie_map_pkg::REGS_PER_PAGE-1:0]           slot_wr_en,
    input  queue_pkg::queue_idx_t                            wr_page,
    input  queue_pkg::ptr_t [pcie_map_pkg::REGS_PER_PAGE-1:0] wr_dword,
    input  logic [pcie_map_pkg::PCIE_ADDR_WIDTH-1:0]         pcie_address_0,
    input  logic                                             pcie_read_0,
    output logic [511:0]                                     pcie_readdata_0,
    output logic                                             pcie_readdatavalid_0
);

    import pcie_map_pkg::*;
    import queue_pkg::*;

    // host-visible copies, tail slot has none
    ptr_t       shadow [NB_QUEUES][REGS_PER_PAGE-1:1];
    logic       reg_read;
    logic       reg_read_q;
    queue_idx_t rd_page_q;

    always_ff @(posedge pcie_clk) begin
        if (!pcie_reset_n) begin
            for (int q = 0; q < NB_QUEUES; q++) begin
                for (int s = 1; s < REGS_PER_PAGE; s++) begin
                    shadow[q][s] <= '0;
                end
            end
        end else begin
            for (int s = 1; s < REGS_PER_PAGE; s++) begin
                if (slot_wr_en[s]) begin
                    shadow[wr_page][s] <= wr_dword[s];
                end
            end
        end
    end

    // only the first lines map to queue pages
    assign reg_read = pcie_read_0 &&
        (pcie_address_0[PCIE_ADDR_WIDTH-1:LINE_LSB] < RB_BRAM_OFFSET);

    always_ff @(posedge pcie_clk) begin
        rd_page_q <= pcie_address_0[PAGE_LSB +: APP_IDX_WIDTH];
        if (!pcie_reset_n) begin
            reg_read_q           <= 1'b0;
            pcie_readdatavalid_0 <= 1'b0;
        end else begin
            reg_read_q           <= reg_read;
            pcie_readdatavalid_0 <= reg_read_q;
        end
    end

    // reply: slot order, low dword first, tail reads as zero
    always_ff @(posedge pcie_clk) begin
        if (reg_read_q) begin
            pcie_readdata_0 <= {
                384'h0,
                shadow[rd_page_q][KMEM_HIGH],
                shadow[rd_page_q][KMEM_LOW],
                shadow[rd_page_q][HEAD],
                32'h0
            };
        end
    end

endmodule

`default_nettype wire

// File: design/pcie_queue_top.sv
`timescale 1ns/1ps
`default_nettype none

module pcie_queue_top #(
    parameter int NB_QUEUES = queue_pkg::MAX_QUEUES
) (
    input  logic                                     pcie_clk,
    input  logic                                     pcie_reset_n,
    input  logic [pcie_map_pkg::PCIE_ADDR_WIDTH-1:0] pcie_address_0,
    input  logic                                     pcie_write_0,
    input  logic                                     pcie_read_0,
    input  logic [511:0]                             pcie_writedata_0,
    input  logic [63:0]                              pcie_byteenable_0,
    output logic [511:0]                             pcie_readdata_0,
    output logic                                     pcie_readdatavalid_0,
    input  logic [queue_pkg::QCOUNT_WIDTH-1:0]       nb_queues,
    input  logic                                     dma_done,
    input  queue_pkg::ptr_t                          new_tail,
    output queue_pkg::queue_idx_t                    active_queue,
    output queue_pkg::ptr_t                          f2c_head,
    output queue_pkg::ptr_t                          f2c_tail,
    output queue_pkg::kmem_addr_t                    f2c_kmem_addr
);

    import pcie_map_pkg::*;
    import queue_pkg::*;

    logic [REGS_PER_PAGE-1:0] slot_wr_en;
    queue_idx_t               wr_page;
    ptr_t [REGS_PER_PAGE-1:0] wr_dword;

    // switcher to table, port a
    queue_idx_t               addr_a;
    logic                     rd_en_a;
    logic                     wr_en_a;
    ptr_t                     tail_wr_data_a;
    ptr_t                     tail_a;
    ptr_t                     head_a;
    kmem_addr_t               kmem_addr_a;

    pio_write_decoder u_wr_dec (
        .pcie_address_0    (pcie_address_0),
        .pcie_write_0      (pcie_write_0),
        .pcie_writedata_0  (pcie_writedata_0),
        .pcie_byteenable_0 (pcie_byteenable_0),
        .slot_wr_en        (slot_wr_en),
        .wr_page           (wr_page),
        .wr_dword          (wr_dword)
    );

    queue_table #(
        .NB_QUEUES (NB_QUEUES)
    ) u_q_table (
        .pcie_clk       (pcie_clk),
        .addr_a         (addr_a),
        .rd_en_a        (rd_en_a),
        .wr_en_a        (wr_en_a),
        .tail_wr_data_a (tail_wr_data_a),
        .slot_wr_en_b   (slot_wr_en),
        .addr_b         (wr_page),
        .wr_dword_b     (wr_dword),
        .tail_a         (tail_a),
        .head_a         (head_a),
        .kmem_addr_a    (kmem_addr_a)
    );

    queue_switcher #(
        .NB_QUEUES (NB_QUEUES)
    ) u_switcher (
        .pcie_clk       (pcie_clk),
        .pcie_reset_n   (pcie_reset_n),
        .nb_queues      (nb_queues),
        .dma_done       (dma_done),
        .new_tail       (new_tail),
        .slot_wr_en     (slot_wr_en),
        .wr_page        (wr_page),
        .wr_dword       (wr_dword),
        .tail_a         (tail_a),
        .head_a         (head_a),
        .kmem_addr_a    (kmem_addr_a),
        .addr_a         (addr_a),
        .rd_en_a        (rd_en_a),
        .wr_en_a        (wr_en_a),
        .tail_wr_data_a (tail_wr_data_a),
        .active_queue   (active_queue),
        .f2c_head       (f2c_head),
        .f2c_tail       (f2c_tail),
        .f2c_kmem_addr  (f2c_kmem_addr)
    );

    pio_reg_file #(
        .NB_QUEUES (NB_QUEUES)
    ) u_reg_file (
        .pcie_clk             (pcie_clk),
        .pcie_reset_n         (pcie_reset_n),
        .slot_wr_en           (slot_wr_en),
        .wr_page              (wr_page),
        .wr_dword             (wr_dword),
        .pcie_address_0       (pcie_address_0),
        .pcie_read_0          (pcie_read_0),
        .pcie_readdata_0      (pcie_readdata_0),
        .pcie_readdatavalid_0 (pcie_readdatavalid_0)
    );

endmodule

`default_nettype wire

// File: test/pcie_queue_properties.sv
`timescale 1ns/1ps
`default_nettype none

module pcie_queue_properties (
    input logic                                     pcie_clk,
    input logic                                     pcie_reset_n,
    input logic [pcie_map_pkg::PCIE_ADDR_WIDTH-1:0] pcie_address_0,
    input logic                                     pcie_read_0,
    input logic                                     pcie_readdatavalid_0,
    input logic [queue_pkg::QCOUNT_WIDTH-1:0]       nb_queues,
    input queue_pkg::queue_idx_t                    active_queue
);

    import pcie_map_pkg::*;
    import queue_pkg::*;

    int   valid_fail_count = 0;
    int   queue_fail_count = 0;
    int   reset_fail_count = 0;
    logic reg_region_read;

    // 64-byte line number below the ring buffer area
    assign reg_region_read = pcie_read_0 &&
        (int'(pcie_address_0[PCIE_ADDR_WIDTH-1:6]) < RB_BRAM_OFFSET);

    // every reply belongs to a register read two cycles back
    valid_after_read: assert property (
        @(posedge pcie_clk) disable iff (!pcie_reset_n)
        pcie_readdatavalid_0 |-> $past(reg_region_read, 2)
    ) else begin
        $error("readdatavalid without a register read two cycles earlier");
        valid_fail_count++;
    end

    active_in_range: assert property (
        @(posedge pcie_clk) disable iff (!pcie_reset_n)
        QCOUNT_WIDTH'(active_queue) < nb_queues
    ) else begin
        $error("active_queue not below nb_queues");
        queue_fail_count++;
    end

    no_valid_after_reset: assert property (
        @(posedge pcie_clk) !pcie_reset_n |=> !pcie_readdatavalid_0
    ) else begin
        $error("readdatavalid high right after reset");
        reset_fail_count++;
    end

endmodule

bind pcie_queue_top pcie_queue_properties u_props (
    .pcie_clk             (pcie_clk),
    .pcie_reset_n         (pcie_reset_n),
    .pcie_address_0       (pcie_address_0),
    .pcie_read_0          (pcie_read_0),
    .pcie_readdatavalid_0 (pcie_readdatavalid_0),
    .nb_queues            (nb_queues),
    .active_queue         (active_queue)
);

`default_nettype wire

// File: test/tb_pcie_queue.sv
`timescale 1ns/1ps
`default_nettype none

module tb_pcie_queue;

    import pcie_map_pkg::*;
    import queue_pkg::*;

    localparam int NQ          = 4;
    localparam int SMALL_NQ    = 2;
    localparam int RAND_WRITES = 32;
    // rough length of each test in cycles, reset and test 1 first
    localparam int TEST_CYCLES = 20 + (NQ + RAND_WRITES) * 4 + 10 + 20 + NQ * 5 + 10 + 30
                                 + 20 + 3 * 5;
    localparam int TIMEOUT_CYCLES = 2 * TEST_CYCLES;

    logic                       pcie_clk;
    logic                       pcie_reset_n;
    logic [PCIE_ADDR_WIDTH-1:0] pcie_address_0;
    logic                       pcie_write_0;
    logic                       pcie_read_0;
    logic [511:0]               pcie_writedata_0;
    logic [63:0]                pcie_byteenable_0;
    logic [511:0]               pcie_readdata_0;
    logic                       pcie_readdatavalid_0;
    logic [QCOUNT_WIDTH-1:0]    nb_queues;
    logic                       dma_done;
    ptr_t                       new_tail;
    queue_idx_t                 active_queue;
    ptr_t                       f2c_head;
    ptr_t                       f2c_tail;
    kmem_addr_t                 f2c_kmem_addr;

    // reference copy of the table, the shadows and the active queue
    ptr_t       ref_tab_tail [NQ];
    ptr_t       ref_head [NQ];
    ptr_t       ref_klo [NQ];
    ptr_t       ref_khi [NQ];
    queue_idx_t ref_active = '0;
    queue_idx_t ref_next = queue_idx_t'(1);
    ptr_t       ref_f2c_head = '0;
    ptr_t       ref_f2c_tail = '0;
    kmem_addr_t ref_f2c_kmem = '0;

    // replies still due, oldest first
    logic [511:0] exp_data_q[$];
    int           exp_cycle_q[$];

    integer seed;
    int     cycle = 0;
    int     errors = 0;
    int     checks = 0;
    int     replies = 0;

    pcie_queue_top #(
        .NB_QUEUES (NQ)
    ) UUT (
        .pcie_clk             (pcie_clk),
        .pcie_reset_n         (pcie_reset_n),
        .pcie_address_0       (pcie_address_0),
        .pcie_write_0         (pcie_write_0),
        .pcie_read_0          (pcie_read_0),
        .pcie_writedata_0     (pcie_writedata_0),
        .pcie_byteenable_0    (pcie_byteenable_0),
        .pcie_readdata_0      (pcie_readdata_0),
        .pcie_readdatavalid_0 (pcie_readdatavalid_0),
        .nb_queues            (nb_queues),
        .dma_done             (dma_done),
        .new_tail             (new_tail),
        .active_queue         (active_queue),
        .f2c_head             (f2c_head),
        .f2c_tail             (f2c_tail),
        .f2c_kmem_addr        (f2c_kmem_addr)
    );

    always #5 pcie_clk = ~pcie_clk;

    always @(posedge pcie_clk) begin
        cycle = cycle + 1;
        if (cycle > TIMEOUT_CYCLES) begin
            $display("ERROR at %0t: run did not end within %0d cycles", $time, TIMEOUT_CYCLES);
            $display("*** FAILED ***");
            $finish;
        end
    end

    // register region is the 64-byte lines below the ring buffer
    function automatic bit is_register_read(input logic [PCIE_ADDR_WIDTH-1:0] addr);
        return int'(addr[PCIE_ADDR_WIDTH-1:6]) < RB_BRAM_OFFSET;
    endfunction

    // page dwords in slot order, tail slot always zero
    function automatic logic [511:0] expected_reply(input logic [PCIE_ADDR_WIDTH-1:0] addr);
        int page;
        page = int'(addr[13:12]);
        return {384'h0, ref_khi[page], ref_klo[page], ref_head[page], 32'h0};
    endfunction

    function automatic logic [127:0] rand128();
        return {$random(seed), $random(seed), $random(seed), $random(seed)};
    endfunction

    // reply checker
    always @(negedge pcie_clk) begin
        logic [511:0] exp_data;
        if (pcie_readdatavalid_0 === 1'b1) begin
            if (exp_cycle_q.size() == 0 || exp_cycle_q[0] != cycle) begin
                $display("ERROR at %0t: pcie_readdatavalid_0 high with no read due", $time);
                errors++;
            end else begin
                exp_data = exp_data_q.pop_front();
                void'(exp_cycle_q.pop_front());
                checks++;
                replies++;
                if (pcie_readdata_0 !== exp_data) begin
                    $display("Mismatch at %0t: pcie_readdata_0 expected %h got %h",
                             $time, exp_data, pcie_readdata_0);
                    errors++;
                end
            end
        end else if (exp_cycle_q.size() != 0 && exp_cycle_q[0] <= cycle) begin
            $display("ERROR at %0t: no pcie_readdatavalid_0 for the read due in cycle %0d",
                     $time, exp_cycle_q[0]);
            errors++;
            void'(exp_data_q.pop_front());
            void'(exp_cycle_q.pop_front());
        end
    end

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        checks++;
        if (got !== exp) begin
            $display("Mismatch at %0t: %s expected %h got %h", $time, name, exp, got);
            errors++;
        end
    endtask

    task automatic check_outputs();
        check_value("active_queue", 64'(active_queue), 64'(ref_active));
        check_value("f2c_head", 64'(f2c_head), 64'(ref_f2c_head));
        check_value("f2c_tail", 64'(f2c_tail), 64'(ref_f2c_tail));
        check_value("f2c_kmem_addr", f2c_kmem_addr, ref_f2c_kmem);
    endtask

    // only fully enabled dwords land, the active page also feeds f2c
    task automatic model_write(input int page, input logic [127:0] data, input logic [15:0] be);
        ptr_t val;
        for (int s = 0; s < REGS_PER_PAGE; s++) begin
            val = data[32*s +: 32];
            if (be[4*s +: 4] == 4'hF) begin
                case (s)
                    0: ref_tab_tail[page] = val;
                    1: ref_head[page] = val;
                    2: ref_klo[page] = val;
                    default: ref_khi[page] = val;
                endcase
                if (page == int'(ref_active)) begin
                    case (s)
                        0: ref_f2c_tail = val;
                        1: ref_f2c_head = val;
                        2: ref_f2c_kmem[31:0] = val;
                        default: ref_f2c_kmem[63:32] = val;
                    endcase
                end
            end
        end
    endtask

    task automatic write_page(input int page, input logic [127:0] data, input logic [15:0] be);
        pcie_address_0    = 16'(page) << PAGE_LSB;
        pcie_writedata_0  = {rand128(), rand128(), rand128(), data};
        pcie_byteenable_0 = {16'($random(seed)), 32'($random(seed)), be};
        pcie_write_0      = 1'b1;
        @(negedge pcie_clk);
        pcie_write_0 = 1'b0;
        model_write(page, data, be);
    endtask

    task automatic read_line(input logic [PCIE_ADDR_WIDTH-1:0] addr);
        pcie_address_0 = addr;
        pcie_read_0    = 1'b1;
        if (is_register_read(addr)) begin
            exp_cycle_q.push_back(cycle + 2);
            exp_data_q.push_back(expected_reply(addr));
        end
        @(negedge pcie_clk);
        pcie_read_0 = 1'b0;
    endtask

    task automatic wait_reads_done();
        int waited;
        waited = 0;
        while (exp_cycle_q.size() != 0 && waited < 8) begin
            @(negedge pcie_clk);
            waited++;
        end
        if (exp_cycle_q.size() != 0) begin
            $display("ERROR at %0t: read replies still missing after 8 cycles", $time);
            errors++;
        end
    endtask

    // extra pulses land while the switch is busy
    task automatic switch_queue(input ptr_t tail, input bit extra_pulses);
        queue_idx_t nq;
        dma_done = 1'b1;
        new_tail = tail;
        @(negedge pcie_clk);
        dma_done = extra_pulses;
        new_tail = $random(seed);
        repeat (2) @(negedge pcie_clk);
        dma_done = 1'b0;
        @(negedge pcie_clk);
        // edge 0 keeps the dma tail, edge 3 saves it and loads the next queue
        ref_f2c_tail = tail;
        ref_tab_tail[ref_active] = ref_f2c_tail;
        nq = ref_next;
        ref_f2c_head = ref_head[nq];
        ref_f2c_kmem = {ref_khi[nq], ref_klo[nq]};
        ref_f2c_tail = ref_tab_tail[nq];
        ref_active = nq;
        // round robin wraps after the last configured queue
        if (int'(nq) >= int'(nb_queues) - 1) begin
            ref_next = queue_idx_t'(0);
        end else begin
            ref_next = queue_idx_t'(nq + 1'b1);
        end
        check_outputs();
    endtask

    task automatic report_test(input string name, input int base);
        if (errors == base) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: %0d errors", name, errors - base);
        end
    endtask

    initial begin
        int           base;
        int           assert_fails;
        logic [15:0]  be;
        logic [31:0]  r;
        ptr_t         first_tail;
        seed              = 33880;
        pcie_clk          = 1'b0;
        pcie_reset_n      = 1'b0;
        pcie_address_0    = '0;
        pcie_write_0      = 1'b0;
        pcie_read_0       = 1'b0;
        pcie_writedata_0  = '0;
        pcie_byteenable_0 = '0;
        nb_queues         = QCOUNT_WIDTH'(NQ);
        dma_done          = 1'b0;
        new_tail          = '0;
        be                = '0;
        r                 = '0;
        for (int q = 0; q < NQ; q++) begin
            ref_tab_tail[q] = '0;
            ref_head[q]     = '0;
            ref_klo[q]      = '0;
            ref_khi[q]      = '0;
        end
        repeat (2) @(negedge pcie_clk);
        pcie_reset_n = 1'b1;

        base = errors;
        check_outputs();
        for (int l = 0; l < RB_BRAM_OFFSET; l++) begin
            read_line(16'(l * 64 + 4 * l));
        end
        wait_reads_done();
        report_test("1 reset state", base);

        // full writes first so every table entry is known
        base = errors;
        for (int q = 0; q < NQ; q++) begin
            write_page(q, rand128(), 16'hFFFF);
            check_outputs();
        end
        for (int i = 0; i < RAND_WRITES; i++) begin
            for (int s = 0; s < REGS_PER_PAGE; s++) begin
                r = $random(seed);
                be[4*s +: 4] = r[4] ? 4'hF : r[3:0];
            end
            write_page(int'(r[9:8]), rand128(), be);
            check_outputs();
            read_line(16'($random(seed)) & 16'h00FF);
        end
        wait_reads_done();
        report_test("2 random writes", base);

        base = errors;
        write_page(0, rand128(), 16'hFFFF);
        check_outputs();
        write_page(2, rand128(), 16'hFFFF);
        check_outputs();
        write_page(0, rand128(), 16'h0F0F);
        check_outputs();
        write_page(1, rand128(), 16'hF0F0);
        check_outputs();
        report_test("3 active page writes", base);

        base = errors;
        first_tail = $random(seed);
        switch_queue(first_tail, 1'b0);
        for (int i = 1; i < NQ; i++) begin
            switch_queue($random(seed), (i % 2) == 1);
        end
        // back on queue 0 with the tail saved when it was left
        checks++;
        if (f2c_tail !== first_tail) begin
            $display("Mismatch at %0t: f2c_tail expected %h got %h", $time, first_tail, f2c_tail);
            errors++;
        end
        report_test("4 queue switch", base);

        base = errors;
        read_line(16'h0100);
        for (int i = 0; i < 8; i++) begin
            read_line(16'($random(seed)) | 16'h0100);
        end
        read_line(16'hFFFF);
        read_line(16'h00FC);
        wait_reads_done();
        repeat (4) @(negedge pcie_clk);
        report_test("5 reads outside register region", base);

        // fewer queues than the table holds, the round must stay below the count
        base = errors;
        pcie_reset_n = 1'b0;
        nb_queues    = QCOUNT_WIDTH'(SMALL_NQ);
        repeat (2) @(negedge pcie_clk);
        pcie_reset_n = 1'b1;
        ref_active   = '0;
        ref_next     = queue_idx_t'(1);
        ref_f2c_head = '0;
        ref_f2c_tail = '0;
        ref_f2c_kmem = '0;
        check_outputs();
        // table keeps its contents across reset
        for (int i = 0; i < 3; i++) begin
            switch_queue($random(seed), 1'b0);
        end
        report_test("6 two-queue round", base);

        assert_fails = UUT.u_props.valid_fail_count + UUT.u_props.queue_fail_count +
                       UUT.u_props.reset_fail_count;
        if (assert_fails != 0) begin
            $display("ERROR: concurrent assertions failed %0d times", assert_fails);
            errors += assert_fails;
        end
        $display("checks: %0d, read replies: %0d, errors: %0d", checks, replies, errors);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: files.f
design/pcie_map_pkg.sv
design/queue_pkg.sv
design/pio_write_decoder.sv
design/queue_table.sv
design/queue_switcher.sv
design/pio_reg_file.sv
design/pcie_queue_top.sv
test/pcie_queue_properties.sv
test/tb_pcie_queue.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the pcie queue testbench with verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --assert -Wno-fatal \
    --top-module tb_pcie_queue \
    -f files.f \
    -o sim_tb_pcie_queue

./obj_dir/sim_tb_pcie_queue +verilator+error+limit+1000 | tee sim.log

if grep -qF '*** PASSED ***' sim.log; then
    echo "run_sim: simulation passed"
    exit 0
else
    echo "run_sim: simulation failed, see sim.log"
    exit 1
fi
